/* rtl/huffman_macros.svh */
`ifndef HUFFMAN_MACROS_SVH
`define HUFFMAN_MACROS_SVH

// Alphabet size and the node count of the full tree built from it.
`define HUF_LEAVES 10
`define HUF_NODES 19

// Node ids are wide enough for 19 nodes plus the two reserved codes.
`define HUF_ID_W 5

// Leaves arrive as bytes.
`define HUF_LEAF_FREQ_W 8

// Internal sums are wider, so ten maximal leaves still fit.
`define HUF_FREQ_W 12

// Child id of a leaf.
`define HUF_NULL_ID {`HUF_ID_W{1'b1}}

// Parent id of the root, and of every node right after a load.
`define HUF_NO_PARENT {`HUF_ID_W{1'b0}}

`endif

/* rtl/huffman_tree_pkg.sv */
`include "huffman_macros.svh"

package huffman_tree_pkg;

	// Leaves are 1 to 10, internal nodes 11 to 19.
	typedef logic [`HUF_ID_W-1:0] node_id_t;

	typedef logic [`HUF_FREQ_W-1:0] freq_t;

	// One merge step.
	// The left child is always the smaller of the pair.
	typedef struct packed {
		node_id_t new_id;
		node_id_t left;
		node_id_t right;
		freq_t    freq;
	} merge_evt_t;

	// One node of the finished tree, as seen on the output.
	// Leaves carry the null id in both child fields.
	typedef struct packed {
		node_id_t id;
		node_id_t parent;
		node_id_t left;
		node_id_t right;
		freq_t    freq;
	} node_rec_t;

endpackage

/* rtl/huffman_stream_pkg.sv */
`include "huffman_macros.svh"

package huffman_stream_pkg;

	import huffman_tree_pkg::*;

	typedef logic [`HUF_LEAF_FREQ_W-1:0] leaf_freq_t;

	// Element 0 is leaf 1, so leaf 1 sits in the lowest byte.
	typedef leaf_freq_t [`HUF_LEAVES-1:0] freq_set_t;

	// One output beat.
	// last marks the nineteenth record of a tree.
	typedef struct packed {
		logic      last;
		node_rec_t rec;
	} rec_beat_t;

endpackage

/* rtl/stream_reg_slice.sv */
`timescale 1ns/1ps

module stream_reg_slice #(
	parameter type payload_t = logic [0:0]
) (
	input  logic     CLK,
	input  logic     nRST,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic     full;
	payload_t data_q;

	// The slot can refill in the same cycle it drains, which keeps full throughput.
	assign in_ready  = !full || out_ready;
	assign out_valid = full;
	assign out_data  = data_q;

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			full <= 1'b0;
		end else if (in_ready) begin
			full <= in_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (in_valid && in_ready) begin
			data_q <= in_data;
		end
	end

endmodule

/* rtl/min_pair_select.sv */
`timescale 1ns/1ps
`include "huffman_macros.svh"

module min_pair_select
	import huffman_tree_pkg::*;
(
	input  logic     [`HUF_LEAVES-1:0] live,
	input  node_id_t [`HUF_LEAVES-1:0] ids,
	input  freq_t    [`HUF_LEAVES-1:0] freqs,
	output logic     [3:0]             lo_idx,
	output logic     [3:0]             hi_idx
);

	// Lower frequency wins; on equal frequency the lower id wins.
	// Ids are unique among live nodes, so the order is total.
	function automatic logic smaller(
		input node_id_t id_a,
		input freq_t    freq_a,
		input node_id_t id_b,
		input freq_t    freq_b
	);
		return (freq_a < freq_b) || ((freq_a == freq_b) && (id_a < id_b));
	endfunction

	always_comb begin
		logic [3:0] lo;
		logic [3:0] hi;
		logic       lo_ok;
		logic       hi_ok;

		lo    = '0;
		hi    = '0;
		lo_ok = 1'b0;
		hi_ok = 1'b0;

		// Dead slots are skipped.
		// A new minimum pushes the old one down to second place.
		for (int i = 0; i < `HUF_LEAVES; i++) begin
			if (live[i]) begin
				if (!lo_ok || smaller(ids[i], freqs[i], ids[lo], freqs[lo])) begin
					hi    = lo;
					hi_ok = lo_ok;
					lo    = 4'(i);
					lo_ok = 1'b1;
				end else if (!hi_ok || smaller(ids[i], freqs[i], ids[hi], freqs[hi])) begin
					hi    = 4'(i);
					hi_ok = 1'b1;
				end
			end
		end

		lo_idx = lo;
		hi_idx = hi;
	end

endmodule

/* rtl/merge_stage.sv */
`timescale 1ns/1ps
`include "huffman_macros.svh"

module merge_stage
	import huffman_tree_pkg::*, huffman_stream_pkg::*;
(
	input  logic       CLK,
	input  logic       nRST,
	input  logic       set_valid,
	output logic       set_ready,
	input  freq_set_t  set_data,
	input  logic       emit_busy,
	output logic       load,
	output freq_set_t  leaf_freqs,
	output logic       evt_valid,
	output merge_evt_t evt,
	output logic       build_done
);

	localparam int LAST_STEP = `HUF_LEAVES - 2;

	node_id_t [`HUF_LEAVES-1:0] slot_id;
	freq_t    [`HUF_LEAVES-1:0] slot_freq;
	logic     [`HUF_LEAVES-1:0] live;
	logic     [3:0]             step;
	logic                       building;
	logic     [3:0]             lo_idx;
	logic     [3:0]             hi_idx;

	min_pair_select pair_sel_i (
		.live   (live),
		.ids    (slot_id),
		.freqs  (slot_freq),
		.lo_idx (lo_idx),
		.hi_idx (hi_idx)
	);

	// The table is shared with the emitter.
	// No new set is taken until the previous tree has left it.
	assign set_ready  = !building && !build_done && !emit_busy;
	assign load       = set_valid && set_ready;
	assign leaf_freqs = set_data;

	// One merge per cycle while building; step 0 creates node 11.
	assign evt_valid  = building;
	assign evt.new_id = node_id_t'(`HUF_LEAVES + 1) + node_id_t'(step);
	assign evt.left   = slot_id[lo_idx];
	assign evt.right  = slot_id[hi_idx];
	assign evt.freq   = slot_freq[lo_idx] + slot_freq[hi_idx];

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			building   <= 1'b0;
			step       <= '0;
			live       <= '0;
			build_done <= 1'b0;
		end else begin
			build_done <= 1'b0;
			if (load) begin
				building <= 1'b1;
				step     <= '0;
				live     <= '1;
			end else if (building) begin
				live[hi_idx] <= 1'b0;
				if (step == 4'(LAST_STEP)) begin
					building   <= 1'b0;
					build_done <= 1'b1;
				end else begin
					step <= step + 4'd1;
				end
			end
		end
	end

	// The merged node reuses the slot of its left child.
	// The slot of the right child is retired above.
	always_ff @(posedge CLK) begin
		if (load) begin
			for (int i = 0; i < `HUF_LEAVES; i++) begin
				slot_id[i]   <= node_id_t'(i + 1);
				slot_freq[i] <= freq_t'(set_data[i]);
			end
		end else if (building) begin
			slot_id[lo_idx]   <= evt.new_id;
			slot_freq[lo_idx] <= evt.freq;
		end
	end

endmodule

/* rtl/tree_table.sv */
`timescale 1ns/1ps
`include "huffman_macros.svh"

module tree_table
	import huffman_tree_pkg::*, huffman_stream_pkg::*;
(
	input  logic       CLK,
	input  logic       nRST,
	input  logic       load,
	input  freq_set_t  leaf_freqs,
	input  logic       evt_valid,
	input  merge_evt_t evt,
	input  node_id_t   rd_id,
	output node_rec_t  rd_rec
);

	// Entries are addressed directly by node id.
	node_id_t parent [1:`HUF_NODES];
	node_id_t left   [1:`HUF_NODES];
	node_id_t right  [1:`HUF_NODES];
	freq_t    freq   [1:`HUF_NODES];

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			for (int i = 1; i <= `HUF_NODES; i++) begin
				parent[i] <= `HUF_NO_PARENT;
			end
		end else if (load) begin
			for (int i = 1; i <= `HUF_NODES; i++) begin
				parent[i] <= `HUF_NO_PARENT;
			end
		end else if (evt_valid) begin
			parent[evt.left]  <= evt.new_id;
			parent[evt.right] <= evt.new_id;
		end
	end

	// Internal entries are not cleared on load.
	// Every one of them is rewritten by its merge before readout starts.
	always_ff @(posedge CLK) begin
		if (load) begin
			for (int i = 1; i <= `HUF_LEAVES; i++) begin
				left[i]  <= `HUF_NULL_ID;
				right[i] <= `HUF_NULL_ID;
				freq[i]  <= freq_t'(leaf_freqs[i-1]);
			end
		end else if (evt_valid) begin
			left[evt.new_id]  <= evt.left;
			right[evt.new_id] <= evt.right;
			freq[evt.new_id]  <= evt.freq;
		end
	end

	assign rd_rec.id     = rd_id;
	assign rd_rec.parent = parent[rd_id];
	assign rd_rec.left   = left[rd_id];
	assign rd_rec.right  = right[rd_id];
	assign rd_rec.freq   = freq[rd_id];

endmodule

/* rtl/record_emitter.sv */
`timescale 1ns/1ps
`include "huffman_macros.svh"

module record_emitter
	import huffman_tree_pkg::*, huffman_stream_pkg::*;
(
	input  logic      CLK,
	input  logic      nRST,
	input  logic      build_done,
	output logic      busy,
	output node_id_t  rd_id,
	input  node_rec_t rd_rec,
	output logic      out_valid,
	input  logic      out_ready,
	output rec_beat_t out_beat
);

	localparam node_id_t FIRST_ID = node_id_t'(1);
	localparam node_id_t LAST_ID  = node_id_t'(`HUF_NODES);

	logic     active;
	node_id_t cnt;
	logic     at_last;

	assign at_last = (cnt == LAST_ID);

	// The table read is combinational, so the record follows the id in the same cycle.
	assign rd_id         = cnt;
	assign busy          = active;
	assign out_valid     = active;
	assign out_beat.rec  = rd_rec;
	assign out_beat.last = at_last;

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			active <= 1'b0;
			cnt    <= FIRST_ID;
		end else if (build_done) begin
			active <= 1'b1;
			cnt    <= FIRST_ID;
		end else if (active && out_ready) begin
			// Without ready the id stays put, so no record is skipped.
			if (at_last) begin
				active <= 1'b0;
			end else begin
				cnt <= cnt + node_id_t'(1);
			end
		end
	end

endmodule

/* rtl/huffman_tree_builder.sv */
`timescale 1ns/1ps

module huffman_tree_builder
	import huffman_tree_pkg::*, huffman_stream_pkg::*;
(
	input  logic      CLK,
	input  logic      nRST,
	input  logic      in_valid,
	output logic      in_ready,
	input  freq_set_t in_data,
	output logic      out_valid,
	input  logic      out_ready,
	output rec_beat_t out_data
);

	logic       set_valid;
	logic       set_ready;
	freq_set_t  set_data;
	logic       emit_busy;
	logic       load;
	freq_set_t  leaf_freqs;
	logic       evt_valid;
	merge_evt_t evt;
	logic       build_done;
	node_id_t   rd_id;
	node_rec_t  rd_rec;
	logic       beat_valid;
	logic       beat_ready;
	rec_beat_t  beat;

	stream_reg_slice #(.payload_t(freq_set_t)) in_slice (
		.CLK       (CLK),
		.nRST      (nRST),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.out_valid (set_valid),
		.out_ready (set_ready),
		.out_data  (set_data)
	);

	merge_stage merge_i (
		.CLK        (CLK),
		.nRST       (nRST),
		.set_valid  (set_valid),
		.set_ready  (set_ready),
		.set_data   (set_data),
		.emit_busy  (emit_busy),
		.load       (load),
		.leaf_freqs (leaf_freqs),
		.evt_valid  (evt_valid),
		.evt        (evt),
		.build_done (build_done)
	);

	tree_table table_i (
		.CLK        (CLK),
		.nRST       (nRST),
		.load       (load),
		.leaf_freqs (leaf_freqs),
		.evt_valid  (evt_valid),
		.evt        (evt),
		.rd_id      (rd_id),
		.rd_rec     (rd_rec)
	);

	record_emitter emit_i (
		.CLK        (CLK),
		.nRST       (nRST),
		.build_done (build_done),
		.busy       (emit_busy),
		.rd_id      (rd_id),
		.rd_rec     (rd_rec),
		.out_valid  (beat_valid),
		.out_ready  (beat_ready),
		.out_beat   (beat)
	);

	stream_reg_slice #(.payload_t(rec_beat_t)) out_slice (
		.CLK       (CLK),
		.nRST      (nRST),
		.in_valid  (beat_valid),
		.in_ready  (beat_ready),
		.in_data   (beat),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

endmodule

/* test/tb_huffman_model.svh */
`ifndef TB_HUFFMAN_MODEL_SVH
`define TB_HUFFMAN_MODEL_SVH

// Expected tree of the set being read out, indexed by node id.
node_rec_t exp_tree [1:`HUF_NODES];

// Lower frequency comes first; equal frequencies go by the lower id.
function automatic bit precedes(input int a, input int b);
	return (exp_tree[a].freq < exp_tree[b].freq) ||
		((exp_tree[a].freq == exp_tree[b].freq) && (a < b));
endfunction

task automatic build_model(input freq_set_t fs);
	bit alive [1:`HUF_NODES];
	int lo;
	int hi;
	for (int i = 1; i <= `HUF_NODES; i++) begin
		exp_tree[i].id     = node_id_t'(i);
		exp_tree[i].parent = `HUF_NO_PARENT;
		exp_tree[i].left   = `HUF_NULL_ID;
		exp_tree[i].right  = `HUF_NULL_ID;
		exp_tree[i].freq   = '0;
		alive[i]           = (i <= `HUF_LEAVES);
	end
	for (int i = 1; i <= `HUF_LEAVES; i++) begin
		exp_tree[i].freq = freq_t'(fs[i-1]);
	end
	// Each merge joins the first and second live node in tie order.
	for (int n = `HUF_LEAVES + 1; n <= `HUF_NODES; n++) begin
		lo = 0;
		for (int i = 1; i < n; i++) begin
			if (alive[i] && (lo == 0 || precedes(i, lo))) begin
				lo = i;
			end
		end
		hi = 0;
		for (int i = 1; i < n; i++) begin
			if (alive[i] && i != lo && (hi == 0 || precedes(i, hi))) begin
				hi = i;
			end
		end
		exp_tree[n].left    = node_id_t'(lo);
		exp_tree[n].right   = node_id_t'(hi);
		exp_tree[n].freq    = exp_tree[lo].freq + exp_tree[hi].freq;
		exp_tree[lo].parent = node_id_t'(n);
		exp_tree[hi].parent = node_id_t'(n);
		alive[lo] = 1'b0;
		alive[hi] = 1'b0;
		alive[n]  = 1'b1;
	end
endtask

task automatic compare_field(input string name, input int node,
		input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp) begin
		rec_errors++;
		$display("error at %0t: out_data.rec.%s of node %0d got %0d expected %0d",
			$time, name, node, got, exp);
	end
endtask

task automatic check_rec(input node_rec_t got, input node_rec_t exp);
	compare_field("id", exp.id, 32'(got.id), 32'(exp.id));
	compare_field("parent", exp.id, 32'(got.parent), 32'(exp.parent));
	compare_field("left", exp.id, 32'(got.left), 32'(exp.left));
	compare_field("right", exp.id, 32'(got.right), 32'(exp.right));
	compare_field("freq", exp.id, 32'(got.freq), 32'(exp.freq));
endtask

task automatic check_last(input logic got, input logic exp);
	if (got !== exp) begin
		last_errors++;
		$display("error at %0t: out_data.last got %b expected %b", $time, got, exp);
	end
endtask

`endif

/* test/tb_huffman_tree_builder.sv */
`timescale 1ns/1ps
`include "huffman_macros.svh"

module tb_huffman_tree_builder
	import huffman_tree_pkg::*, huffman_stream_pkg::*;
();

	localparam int          NUM_SETS       = 250;
	localparam int          TIMEOUT_CYCLES = NUM_SETS * 60 + 500;
	localparam logic [31:0] SEED           = 32'ha062_bb99;

	logic      CLK;
	logic      nRST;
	logic      in_valid;
	logic      in_ready;
	freq_set_t in_data;
	logic      out_valid;
	logic      out_ready;
	rec_beat_t out_data;

	int rec_errors   = 0;
	int last_errors  = 0;
	int other_errors = 0;

	`include "tb_huffman_model.svh"

	freq_set_t   accepted [$];
	int          trees_done = 0;
	int          rec_idx    = 1;
	int          roots      = 0;
	logic [31:0] rnd_set    = SEED;

	huffman_tree_builder dut_i (
		.CLK       (CLK),
		.nRST      (nRST),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// The first sets cover ties, zeros and maximum values; the rest are random.
	// Every third random set uses small values, so duplicates are common.
	function automatic freq_set_t make_set(input int n);
		freq_set_t fs;
		for (int i = 0; i < `HUF_LEAVES; i++) begin
			rnd_set = xorshift32(rnd_set);
			case (n)
				0: fs[i] = 8'd7;
				1: fs[i] = 8'(3 + 2 * (i % 3));
				2: fs[i] = (i % 2 == 0) ? 8'd0 : 8'hff;
				3: fs[i] = 8'hff;
				4: fs[i] = 8'd0;
				5: fs[i] = (i < 5) ? 8'd4 : 8'd2;
				default: fs[i] = (n % 3 == 0) ? {4'd0, rnd_set[3:0]} : rnd_set[7:0];
			endcase
		end
		return fs;
	endfunction

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	initial begin
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge CLK);
			cycles++;
		end
		$display("timeout: only %0d of %0d trees were read out after %0d cycles",
			trees_done, NUM_SETS, cycles);
		$display("FAIL: see errors above");
		$finish;
	end

	// Output ready stays high for the first trees, then drops about a quarter of the time.
	initial begin
		logic [31:0] rnd_rdy;
		rnd_rdy   = SEED;
		out_ready = 1'b1;
		forever begin
			@(posedge CLK);
			#1;
			rnd_rdy   = xorshift32(rnd_rdy);
			out_ready = (trees_done < 60) || (rnd_rdy[2:1] != 2'b00);
		end
	end

	initial begin
		freq_set_t fs;
		nRST     = 1'b0;
		in_valid = 1'b0;
		in_data  = '0;
		repeat (8) @(posedge CLK);
		#1;
		nRST = 1'b1;
		@(negedge CLK);
		if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
			other_errors++;
			$display("out_valid is not low or in_ready is not high after reset");
		end
		@(posedge CLK);
		#1;
		for (int n = 0; n < NUM_SETS; n++) begin
			fs       = make_set(n);
			in_data  = fs;
			in_valid = 1'b1;
			@(negedge CLK);
			while (in_ready !== 1'b1) begin
				@(negedge CLK);
			end
			accepted.push_back(fs);
			@(posedge CLK);
			#1;
			in_valid = 1'b0;
			if (n >= 150 && fs[0][0]) begin
				repeat (int'(fs[1][1:0]) + 1) begin
					@(posedge CLK);
					#1;
				end
			end
		end
		wait (trees_done == NUM_SETS);
		repeat (4) @(negedge CLK);
		if (out_valid !== 1'b0) begin
			other_errors++;
			$display("output did not go quiet after the last tree");
		end
		$display("errors: record %0d, last flag %0d, other %0d",
			rec_errors, last_errors, other_errors);
		if (rec_errors + last_errors + other_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// Outputs are sampled at the falling edge, between input changes and the next transfer.
	initial begin
		freq_set_t cur_set;
		freq_t     leaf_sum;
		cur_set = '0;
		forever begin
			@(negedge CLK);
			if (out_valid === 1'b1 && out_ready === 1'b1) begin
				if (rec_idx == 1) begin
					if (accepted.size() == 0) begin
						other_errors++;
						$display("a record left the DUT at %0t with no set accepted", $time);
					end else begin
						cur_set = accepted.pop_front();
					end
					build_model(cur_set);
					roots = 0;
				end
				check_rec(out_data.rec, exp_tree[rec_idx]);
				check_last(out_data.last, rec_idx == `HUF_NODES);
				if (out_data.rec.parent == `HUF_NO_PARENT) begin
					roots++;
				end
				if (rec_idx == `HUF_NODES) begin
					leaf_sum = '0;
					for (int i = 0; i < `HUF_LEAVES; i++) begin
						leaf_sum += freq_t'(cur_set[i]);
					end
					compare_field("freq", rec_idx, 32'(out_data.rec.freq), 32'(leaf_sum));
					if (roots != 1) begin
						other_errors++;
						$display("tree %0d has %0d nodes without a parent", trees_done, roots);
					end
					trees_done++;
					rec_idx = 1;
				end else begin
					rec_idx++;
				end
			end
		end
	end

endmodule

/* verilog.f */
+incdir+rtl
+incdir+test
rtl/huffman_tree_pkg.sv
rtl/huffman_stream_pkg.sv
rtl/stream_reg_slice.sv
rtl/min_pair_select.sv
rtl/merge_stage.sv
rtl/tree_table.sv
rtl/record_emitter.sv
rtl/huffman_tree_builder.sv
test/tb_huffman_tree_builder.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_huffman_tree_builder -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -qx "PASS: all tests" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
